// File: include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path width in bits.
`define XLEN 32

// Address of the first fetch after reset.
`define RESET_PC 0

// Byte distance between two sequential instructions.
`define PC_STEP 4

`endif

// File: hw/rvDecodePkg.sv
`include "rv_settings.svh"

package rvDecodePkg;

    typedef logic [31:0]       instrWord;
    typedef logic [`XLEN-1:0]  dataWord;
    typedef logic [4:0]        regIdx;

    // One-hot byte count of a memory access.
    typedef logic [2:0] memSize;
    localparam memSize SIZE_NONE = 3'b000;
    localparam memSize SIZE_BYTE = 3'b001;
    localparam memSize SIZE_HALF = 3'b010;
    localparam memSize SIZE_WORD = 3'b100;

    typedef logic [2:0] aluCtrl;
    localparam aluCtrl ALU_ADD = 3'b000;
    localparam aluCtrl ALU_SUB = 3'b001;
    localparam aluCtrl ALU_SLL = 3'b010;
    localparam aluCtrl ALU_SLT = 3'b011;
    localparam aluCtrl ALU_XOR = 3'b100;
    localparam aluCtrl ALU_SRL = 3'b101;
    localparam aluCtrl ALU_OR  = 3'b110;
    localparam aluCtrl ALU_AND = 3'b111;

    typedef enum logic [3:0] {
        UNDEFINED, R_TYPE, ADDI, SLLI, L_TYPE, LUI, S_TYPE, B_TYPE, JAL, JALR
    } instrClass;

    typedef struct packed {
        logic     valid;
        dataWord  pc;
        instrWord instr;
    } fetchBundle;

    typedef struct packed {
        logic       regWrite;
        logic [1:0] resultSrc;
        logic       aluSrc;
        logic       branch;
        logic       jump;
        logic       jalr;
        logic       lui;
        logic       memWrite;
        aluCtrl     aluControl;
        memSize     regSize;
        memSize     dmemSize;
        logic       loadSigned;
    } ctrlBundle;

    // No effects, but the data memory side still sees a word access.
    localparam ctrlBundle CTRL_BUBBLE = '{dmemSize: SIZE_WORD, default: '0};

    typedef struct packed {
        logic      valid;
        dataWord   pc;
        regIdx     rs1;
        regIdx     rs2;
        regIdx     rd;
        dataWord   imm;
        ctrlBundle ctrl;
    } decodeBundle;

endpackage

// File: hw/fetchUnit.sv
`include "rv_settings.svh"

module fetchUnit import rvDecodePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       redirect,
    input  dataWord    redirectPc,
    output dataWord    imemAddr,
    input  instrWord   imemData,
    output fetchBundle fetchOut
);

    dataWord  pcQ;
    logic     validQ;
    dataWord  ifPcQ;
    instrWord ifInstrQ;

    // Program counter. Redirect has priority over stall.
    always_ff @(posedge clk) begin
        if (reset) begin
            pcQ <= dataWord'(`RESET_PC);
        end else if (redirect) begin
            pcQ <= redirectPc;
        end else if (!stall) begin
            pcQ <= pcQ + dataWord'(`PC_STEP);
        end
    end

    // IF/ID valid bit.
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            validQ <= 1'b0;
        end else if (!stall) begin
            validQ <= 1'b1;
        end
    end

    // IF/ID payload, held while stalled.
    always_ff @(posedge clk) begin
        if (!stall) begin
            ifPcQ    <= pcQ;
            ifInstrQ <= imemData;
        end
    end

    assign imemAddr = pcQ;

    assign fetchOut = '{valid: validQ, pc: ifPcQ, instr: ifInstrQ};

endmodule

// File: hw/mainDecoder.sv
module mainDecoder import rvDecodePkg::*; (
    input  logic [2:0] funct3,
    input  logic [6:0] opcode,
    output ctrlBundle  ctrl,
    output logic [1:0] aluOp,
    output logic [2:0] immSrc
);

    instrClass cls;

    // Opcode classification.
    always_comb begin
        case (opcode)
            7'b0110011: cls = R_TYPE;
            // Every nonzero funct3 falls into the shift class.
            7'b0010011: cls = (funct3 == 3'b000) ? ADDI : SLLI;
            7'b0000011: cls = L_TYPE;
            7'b0110111: cls = LUI;
            7'b0100011: cls = S_TYPE;
            7'b1100011: cls = B_TYPE;
            7'b1101111: cls = JAL;
            7'b1100111: cls = JALR;
            default:    cls = UNDEFINED;
        endcase
    end

    // Main control fields.
    always_comb begin
        ctrl = CTRL_BUBBLE;
        ctrl.regWrite = cls inside {R_TYPE, ADDI, SLLI, L_TYPE, LUI, JAL, JALR};
        case (cls)
            L_TYPE:    ctrl.resultSrc = 2'b01;
            JAL, JALR: ctrl.resultSrc = 2'b10;
            default:   ctrl.resultSrc = 2'b00;
        endcase
        ctrl.aluSrc   = cls inside {ADDI, SLLI, L_TYPE, LUI, S_TYPE};
        ctrl.branch   = (cls == B_TYPE);
        ctrl.jump     = cls inside {JAL, JALR};
        ctrl.jalr     = (cls == JALR);
        ctrl.lui      = (cls == LUI);
        ctrl.memWrite = (cls == S_TYPE);
        // Filled in later by the ALU decoder.
        ctrl.aluControl = ALU_ADD;

        // Access sizes.
        ctrl.regSize    = SIZE_NONE;
        ctrl.dmemSize   = SIZE_WORD;
        ctrl.loadSigned = 1'b0;
        if (cls == L_TYPE) begin
            case (funct3)
                3'b010:         ctrl.dmemSize = SIZE_WORD;
                3'b001, 3'b101: ctrl.dmemSize = SIZE_HALF;
                3'b000, 3'b100: ctrl.dmemSize = SIZE_BYTE;
                default:        ctrl.dmemSize = SIZE_WORD;
            endcase
            ctrl.loadSigned = (funct3 == 3'b000) || (funct3 == 3'b001);
        end else if (cls == S_TYPE) begin
            case (funct3)
                3'b010:  ctrl.regSize = SIZE_WORD;
                3'b001:  ctrl.regSize = SIZE_HALF;
                3'b000:  ctrl.regSize = SIZE_BYTE;
                default: ctrl.regSize = SIZE_NONE;
            endcase
        end
    end

    // Immediate format select. Jalr uses the I format.
    always_comb begin
        case (cls)
            LUI:     immSrc = 3'b001;
            S_TYPE:  immSrc = 3'b010;
            B_TYPE:  immSrc = 3'b011;
            JAL:     immSrc = 3'b100;
            default: immSrc = 3'b000;
        endcase
    end

    // Hint to the ALU decoder.
    always_comb begin
        case (cls)
            L_TYPE, S_TYPE: aluOp = 2'b00;
            B_TYPE:         aluOp = 2'b01;
            default:        aluOp = 2'b10;
        endcase
    end

endmodule

// File: hw/aluDecoder.sv
module aluDecoder import rvDecodePkg::*; (
    input  logic [1:0] aluOp,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       opb5,
    output aluCtrl     aluControl
);

    logic isSub;

    // Only register-register forms can subtract.
    assign isSub = funct7b5 && opb5;

    always_comb begin
        case (aluOp)
            2'b00: aluControl = ALU_ADD;
            // Branch compare.
            2'b01: aluControl = ALU_SUB;
            2'b10: begin
                case (funct3)
                    3'b000:  aluControl = isSub ? ALU_SUB : ALU_ADD;
                    3'b001:  aluControl = ALU_SLL;
                    3'b010:  aluControl = ALU_SLT;
                    3'b100:  aluControl = ALU_XOR;
                    3'b101:  aluControl = ALU_SRL;
                    3'b110:  aluControl = ALU_OR;
                    3'b111:  aluControl = ALU_AND;
                    default: aluControl = ALU_ADD;
                endcase
            end
            default: aluControl = ALU_ADD;
        endcase
    end

endmodule

// File: hw/immGen.sv
module immGen import rvDecodePkg::*; (
    input  instrWord   instr,
    input  logic [2:0] immSrc,
    output dataWord    imm
);

    // The signed casts extend bit 31 of the instruction over the upper bits.
    always_comb begin
        case (immSrc)
            3'b001: imm = dataWord'($signed({instr[31:12], 12'b0}));
            3'b010: imm = dataWord'($signed({instr[31:25], instr[11:7]}));
            3'b011: begin
                imm = dataWord'($signed({instr[31], instr[7], instr[30:25],
                                         instr[11:8], 1'b0}));
            end
            3'b100: begin
                imm = dataWord'($signed({instr[31], instr[19:12], instr[20],
                                         instr[30:21], 1'b0}));
            end
            // I format.
            default: imm = dataWord'($signed(instr[31:20]));
        endcase
    end

endmodule

// File: hw/decodeStage.sv
module decodeStage import rvDecodePkg::*; (
    input  fetchBundle  fetchIn,
    output decodeBundle decodeOut
);

    ctrlBundle  mainCtrl;
    logic [1:0] aluOp;
    logic [2:0] immSrc;
    aluCtrl     aluControl;
    dataWord    imm;

    mainDecoder mainDec0 (
        .funct3 (fetchIn.instr[14:12]),
        .opcode (fetchIn.instr[6:0]),
        .ctrl   (mainCtrl),
        .aluOp  (aluOp),
        .immSrc (immSrc)
    );

    aluDecoder aluDec0 (
        .aluOp      (aluOp),
        .funct3     (fetchIn.instr[14:12]),
        .funct7b5   (fetchIn.instr[30]),
        .opb5       (fetchIn.instr[5]),
        .aluControl (aluControl)
    );

    immGen immGen0 (
        .instr  (fetchIn.instr),
        .immSrc (immSrc),
        .imm    (imm)
    );

    always_comb begin
        decodeOut.valid = fetchIn.valid;
        decodeOut.pc    = fetchIn.pc;
        decodeOut.rs1   = regIdx'(fetchIn.instr[19:15]);
        decodeOut.rs2   = regIdx'(fetchIn.instr[24:20]);
        decodeOut.rd    = regIdx'(fetchIn.instr[11:7]);
        decodeOut.imm   = imm;
        decodeOut.ctrl  = mainCtrl;
        decodeOut.ctrl.aluControl = aluControl;
        // An empty IF/ID slot must not reach execute with any effect.
        if (!fetchIn.valid) begin
            decodeOut.ctrl = CTRL_BUBBLE;
        end
    end

endmodule

// File: hw/idExRegister.sv
module idExRegister import rvDecodePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        redirect,
    input  decodeBundle decodeIn,
    output decodeBundle exBundle
);

    logic      validQ;
    ctrlBundle ctrlQ;
    dataWord   pcQ;
    regIdx     rs1Q;
    regIdx     rs2Q;
    regIdx     rdQ;
    dataWord   immQ;

    // Bubble on reset, stall or redirect.
    always_ff @(posedge clk) begin
        if (reset || stall || redirect) begin
            validQ <= 1'b0;
            ctrlQ  <= CTRL_BUBBLE;
        end else begin
            validQ <= decodeIn.valid;
            ctrlQ  <= decodeIn.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        pcQ  <= decodeIn.pc;
        rs1Q <= decodeIn.rs1;
        rs2Q <= decodeIn.rs2;
        rdQ  <= decodeIn.rd;
        immQ <= decodeIn.imm;
    end

    assign exBundle = '{
        valid: validQ,
        pc:    pcQ,
        rs1:   rs1Q,
        rs2:   rs2Q,
        rd:    rdQ,
        imm:   immQ,
        ctrl:  ctrlQ
    };

endmodule

// File: hw/decodeTop.sv
module decodeTop import rvDecodePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        redirect,
    input  dataWord     redirectPc,
    output dataWord     imemAddr,
    input  instrWord    imemData,
    output decodeBundle exBundle
);

    fetchBundle  ifId;
    decodeBundle idDecoded;

    fetchUnit fetch0 (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .fetchOut   (ifId)
    );

    decodeStage decode0 (
        .fetchIn   (ifId),
        .decodeOut (idDecoded)
    );

    idExRegister idEx0 (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .redirect (redirect),
        .decodeIn (idDecoded),
        .exBundle (exBundle)
    );

endmodule

// File: tb/clockGen.sv
module clockGen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule

// File: tb/decodeChk.sv
module decodeChk import rvDecodePkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        redirect,
    input decodeBundle exBundle
);

    timeunit 1ns;
    timeprecision 100ps;

    ctrlBundle c;

    assign c = exBundle.ctrl;

    // A register write and a store never issue together.
    assert property (@(posedge clk) disable iff (reset)
        !(c.regWrite && c.memWrite))
        else $error("regWrite and memWrite both set in ID/EX");

    // Redirect flushes the execute slot.
    assert property (@(posedge clk) disable iff (reset)
        redirect |=> !exBundle.valid)
        else $error("ID/EX valid after a redirect");

    // Bubbles carry no effects, only a word-sized memory access.
    assert property (@(posedge clk) disable iff (reset)
        !exBundle.valid |-> (c.dmemSize == 3'b100 &&
            {c.regWrite, c.resultSrc, c.aluSrc, c.branch, c.jump, c.jalr, c.lui,
             c.memWrite, c.aluControl, c.regSize, c.loadSigned} == '0))
        else $error("ID/EX bubble carries nonzero control fields");

endmodule

bind idExRegister decodeChk chk0 (
    .clk      (clk),
    .reset    (reset),
    .redirect (redirect),
    .exBundle (exBundle)
);

// File: tb/decodeTb.sv
`include "rv_settings.svh"

module decodeTb import rvDecodePkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 400;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        redirect;
    dataWord     redirectPc;
    dataWord     imemAddr;
    instrWord    imemData;
    decodeBundle exBundle;

    instrWord    rom [0:63];
    instrWord    progWords [$];
    decodeBundle capQ [$];
    int          invalidCount;
    int          cycleCount;
    integer      seed;

    clockGen clkGen0 (.clk(clk));

    decodeTop dut0 (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .exBundle   (exBundle)
    );

    // Asynchronous instruction ROM.
    assign imemData = rom[imemAddr[7:2]];

    // Collect execute bundles mid-cycle, where they are stable.
    always @(negedge clk) begin
        if (!reset) begin
            if (exBundle.valid) begin
                capQ.push_back(exBundle);
            end else begin
                invalidCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic checkValue(input string name, input logic [63:0] act,
                              input logic [63:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, act, exp);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Reference control fields, built from the decode tables.
    function automatic ctrlBundle refCtrl(input instrWord w);
        ctrlBundle  c;
        logic [1:0] aluOp;
        logic [2:0] f3;
        f3 = w[14:12];
        c = '0;
        c.dmemSize = 3'b100;
        aluOp = 2'b10;
        case (w[6:0])
            7'b0110011: c.regWrite = 1'b1;
            7'b0010011: begin
                c.regWrite = 1'b1;
                c.aluSrc = 1'b1;
            end
            7'b0000011: begin
                c.regWrite = 1'b1;
                c.resultSrc = 2'b01;
                c.aluSrc = 1'b1;
                aluOp = 2'b00;
                if (f3 == 3'b001 || f3 == 3'b101) c.dmemSize = 3'b010;
                else if (f3 == 3'b000 || f3 == 3'b100) c.dmemSize = 3'b001;
                c.loadSigned = (f3 == 3'b000 || f3 == 3'b001);
            end
            7'b0110111: begin
                c.regWrite = 1'b1;
                c.aluSrc = 1'b1;
                c.lui = 1'b1;
            end
            7'b0100011: begin
                c.aluSrc = 1'b1;
                c.memWrite = 1'b1;
                aluOp = 2'b00;
                if (f3 == 3'b010) c.regSize = 3'b100;
                else if (f3 == 3'b001) c.regSize = 3'b010;
                else if (f3 == 3'b000) c.regSize = 3'b001;
            end
            7'b1100011: begin
                c.branch = 1'b1;
                aluOp = 2'b01;
            end
            7'b1101111, 7'b1100111: begin
                c.regWrite = 1'b1;
                c.resultSrc = 2'b10;
                c.jump = 1'b1;
                c.jalr = w[3] == 1'b0;
            end
            default: ;
        endcase
        if (aluOp == 2'b01) begin
            c.aluControl = 3'b001;
        end else if (aluOp == 2'b10) begin
            case (f3)
                3'b000:  c.aluControl = (w[30] && w[5]) ? 3'b001 : 3'b000;
                3'b001:  c.aluControl = 3'b010;
                3'b010:  c.aluControl = 3'b011;
                3'b011:  c.aluControl = 3'b000;
                default: c.aluControl = f3;
            endcase
        end
        return c;
    endfunction

    // Reference immediate, chosen by opcode.
    function automatic dataWord refImm(input instrWord w);
        case (w[6:0])
            7'b0110111: return {w[31:12], 12'b0};
            7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
            7'b1100011: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            7'b1101111: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:    return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    task automatic pulseRedirect(input dataWord pc);
        redirect = 1'b1;
        redirectPc = pc;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        capQ.delete();
    endtask

    task automatic waitValid(input int n);
        while (capQ.size() < n) begin
            @(posedge clk);
        end
        #1;
    endtask

    // Undefined opcode with the index in the upper bits.
    task automatic fillRom();
        for (int i = 0; i < 64; i++) begin
            rom[i] = {25'(i), 7'b0001011};
        end
    endtask

    // Runs progWords from address 0 and checks every bundle in order.
    task automatic runProgram(input string tag);
        int        n;
        ctrlBundle expCtrl;
        n = progWords.size();
        fillRom();
        for (int i = 0; i < n; i++) begin
            rom[i] = progWords[i];
        end
        pulseRedirect(dataWord'(0));
        waitValid(n);
        for (int i = 0; i < n; i++) begin
            expCtrl = refCtrl(progWords[i]);
            checkValue({tag, " pc"}, capQ[i].pc, dataWord'(i * `PC_STEP));
            checkValue({tag, " rd"}, capQ[i].rd, progWords[i][11:7]);
            checkValue({tag, " rs1"}, capQ[i].rs1, progWords[i][19:15]);
            checkValue({tag, " rs2"}, capQ[i].rs2, progWords[i][24:20]);
            checkValue({tag, " imm"}, capQ[i].imm, refImm(progWords[i]));
            checkValue({tag, " aluControl"}, capQ[i].ctrl.aluControl,
                       expCtrl.aluControl);
            checkValue({tag, " ctrl"}, capQ[i].ctrl, expCtrl);
        end
    endtask

    task automatic testReset();
        checkValue("reset valid", exBundle.valid, 0);
        checkValue("reset regWrite", exBundle.ctrl.regWrite, 0);
        checkValue("reset memWrite", exBundle.ctrl.memWrite, 0);
        checkValue("reset branch", exBundle.ctrl.branch, 0);
        checkValue("reset jump", exBundle.ctrl.jump, 0);
        checkValue("reset imemAddr", imemAddr, dataWord'(`RESET_PC));
    endtask

    task automatic testClasses();
        progWords = '{32'h002081B3, 32'h40208233, 32'hFFF08293, 32'h00309313,
                      32'h00812383, 32'h12345437, 32'h00312623, 32'h00208863,
                      32'h008000EF, 32'h000280E7, 32'h0020E4B3, 32'h0020F533,
                      32'h0000000B};
        runProgram("class");
    endtask

    task automatic testImmediates();
        logic [31:0] r [5];
        for (int i = 0; i < 5; i++) begin
            r[i] = $random(seed);
        end
        progWords = '{{r[0][31:15], 3'b000, r[0][11:7], 7'b0010011},
                      {r[1][31:7], 7'b0110111},
                      {r[2][31:15], 3'b010, r[2][11:7], 7'b0100011},
                      {r[3][31:15], 3'b000, r[3][11:7], 7'b1100011},
                      {r[4][31:7], 7'b1101111}};
        runProgram("imm");
    endtask

    task automatic testSizes();
        progWords.delete();
        for (int f = 0; f < 8; f++) begin
            progWords.push_back({17'h00412, 3'(f), 5'd6, 7'b0000011});
            progWords.push_back({17'h00612, 3'(f), 5'd8, 7'b0100011});
        end
        runProgram("size");
    endtask

    // Sequential addi words, rd equal to the word index.
    task automatic loadSequence();
        fillRom();
        for (int i = 0; i < 16; i++) begin
            rom[i] = {12'(i), 5'd0, 3'b000, 5'(i), 7'b0010011};
        end
    endtask

    task automatic testStall();
        loadSequence();
        pulseRedirect(dataWord'(0));
        waitValid(2);
        invalidCount = 0;
        stall = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        stall = 1'b0;
        waitValid(8);
        checkValue("stall bubbles", invalidCount, 3);
        for (int i = 0; i < 8; i++) begin
            checkValue("stall pc", capQ[i].pc, dataWord'(i * `PC_STEP));
            checkValue("stall rd", capQ[i].rd, 5'(i));
        end
    endtask

    task automatic testRedirect();
        loadSequence();
        pulseRedirect(dataWord'(0));
        waitValid(3);
        pulseRedirect(dataWord'(32));
        @(negedge clk);
        checkValue("redirect bubble valid", exBundle.valid, 0);
        waitValid(1);
        checkValue("redirect pc", capQ[0].pc, dataWord'(32));
        checkValue("redirect rd", capQ[0].rd, 5'd8);
    endtask

    initial begin
        seed = 32'h5437_00db;
        cycleCount = 0;
        invalidCount = 0;
        reset = 1'b1;
        stall = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        fillRom();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        testReset();
        testClasses();
        testImmediates();
        testSizes();
        testStall();
        testRedirect();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
hw/rvDecodePkg.sv
hw/fetchUnit.sv
hw/mainDecoder.sv
hw/aluDecoder.sv
hw/immGen.sv
hw/decodeStage.sv
hw/idExRegister.sv
hw/decodeTop.sv
tb/clockGen.sv
tb/decodeChk.sv
tb/decodeTb.sv
